//--- Makefile
SRCS := $(shell grep -v '^+' build.f) include/dcache_consts.svh

.PHONY: all run clean

all: obj_dir/Vdcache_tb

obj_dir/Vdcache_tb: $(SRCS) build.f
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module dcache_tb -Mdir obj_dir -o Vdcache_tb

run: obj_dir/Vdcache_tb
	@out="$$(./obj_dir/Vdcache_tb)"; echo "$$out"; \
		echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- build.f
+incdir+include
logic/axi_pkg.sv
logic/dcache_pkg.sv
logic/dcache_fill_if.sv
logic/sram_128x64.sv
logic/dcache_tag_array.sv
logic/dcache_data_array.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/dcache_props.sv
sim/dcache_tb.sv

//--- include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DCACHE_WAYS 4
`define DCACHE_SETS 16

// one line is 4 SRAM rows of 128 bits
`define DCACHE_ROWS 4

// one line is filled by 8 bus beats of 64 bits
`define DCACHE_BEATS 8

// everything at or above this address bypasses the cache
`define DCACHE_DEV_BASE 32'h9000_0000

`endif

//--- logic/axi_pkg.sv
package axi_pkg;

	// byte address on the bus
	typedef logic [31:0] axi_addr_t;

	// one 64-bit beat, also the core data word
	typedef logic [63:0] axi_data_t;

	// one strobe bit per byte of a beat
	typedef logic [7:0] axi_strb_t;

	// burst length minus one
	typedef logic [7:0] axi_len_t;

endpackage

//--- logic/dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_ctrl import axi_pkg::*, dcache_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         valid,
	input  logic         wren,
	input  dcache_addr_u addr,
	input  axi_data_t    din,
	input  axi_strb_t    mask,
	output logic         ready,
	input  way_vec_t     way_hit,
	input  way_vec_t     way_free,
	dcache_fill_if.ctrl  fill,
	output axi_data_t    dev_data,
	output axi_addr_t    araddr,
	output axi_len_t     arlen,
	output logic         arvalid,
	input  logic         arready,
	input  axi_data_t    rdata,
	input  logic         rlast,
	input  logic         rvalid,
	output axi_addr_t    awaddr,
	output logic         awvalid,
	input  logic         awready,
	output axi_data_t    wdata,
	output axi_strb_t    wstrb,
	output logic         wlast,
	output logic         wvalid,
	input  logic         wready,
	input  logic         bvalid
);

	localparam int BEAT_W = $clog2(`DCACHE_BEATS);
	localparam int ROW_W  = $clog2(`DCACHE_ROWS);

	dcache_state_e     state;
	dcache_state_e     state_nxt;
	logic [BEAT_W-1:0] beat_cnt;
	way_vec_t          victim;
	way_vec_t          rr_way;
	logic              ready_nxt;
	logic              rready;
	logic              bready;
	logic              cached;
	logic              hit;
	logic              act;

	// read data and write responses are always accepted
	assign rready = 1'b1;
	assign bready = 1'b1;

	assign cached = axi_addr_t'(addr) < `DCACHE_DEV_BASE;
	assign hit    = |way_hit;
	// no new lookup in the ready cycle, the core still shows the old request
	assign act    = valid && !ready;

	// all bus fields come from the core request, which is held until ready
	assign araddr  = cached ? {addr.bus.line, 6'b0} : axi_addr_t'(addr);
	assign arlen   = cached ? axi_len_t'(`DCACHE_BEATS - 1) : '0;
	assign awaddr  = axi_addr_t'(addr);
	assign wdata   = din;
	assign wstrb   = mask;
	assign awvalid = (state == AW_REQ);
	assign wvalid  = (state == W_DATA);
	assign wlast   = wvalid;

	always_comb begin
		state_nxt       = state;
		ready_nxt       = 1'b0;
		arvalid         = 1'b0;
		fill.sram_en    = '0;
		fill.sram_we    = 1'b0;
		fill.sram_row   = {addr.cache.index, addr.cache.row};
		fill.sram_half  = addr.cache.half;
		fill.sram_wdata = din;
		fill.sram_mask  = mask;
		fill.tag_set    = 1'b0;
		case (state)
			IDLE: begin
				if (act && wren) begin
					// write hit merges into the line, memory is always written
					if (cached && hit) begin
						fill.sram_en = way_hit;
						fill.sram_we = 1'b1;
					end
					state_nxt = AW_REQ;
				end else if (act && cached && hit) begin
					fill.sram_en = way_hit;
					ready_nxt    = 1'b1;
				end else if (act) begin
					arvalid   = 1'b1;
					state_nxt = arready ? (cached ? R_FILL : R_DEV) : AR_REQ;
				end
			end
			AW_REQ: if (awready) state_nxt = W_DATA;
			W_DATA: if (wready) state_nxt = B_WAIT;
			B_WAIT: begin
				if (bvalid && bready) begin
					// write miss goes on to allocate the line
					if (cached && !hit) begin
						state_nxt = AR_REQ;
					end else begin
						state_nxt = IDLE;
						ready_nxt = 1'b1;
					end
				end
			end
			AR_REQ: begin
				arvalid = 1'b1;
				if (arready) state_nxt = cached ? R_FILL : R_DEV;
			end
			R_FILL: begin
				if (rvalid && rready) begin
					// two beats per row, even beat in the low half
					fill.sram_en    = victim;
					fill.sram_we    = 1'b1;
					fill.sram_row   = {addr.cache.index, beat_cnt[BEAT_W-1 -: ROW_W]};
					fill.sram_half  = beat_cnt[0];
					fill.sram_wdata = rdata;
					fill.sram_mask  = '1;
					if (rlast) begin
						fill.tag_set = 1'b1;
						state_nxt    = IDLE;
						// a read lets the next lookup hit, a write is done here
						ready_nxt    = wren;
					end
				end
			end
			R_DEV: begin
				if (rvalid && rready) begin
					state_nxt = IDLE;
					ready_nxt = 1'b1;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			ready    <= 1'b0;
			beat_cnt <= '0;
			victim   <= '0;
			rr_way   <= way_vec_t'(1);
		end else begin
			state <= state_nxt;
			ready <= ready_nxt;
			if (state == IDLE) begin
				beat_cnt <= '0;
				// free way first, rotating pick once the set is full
				victim   <= (|way_free) ? way_free : rr_way;
			end else if (state == R_FILL && rvalid && rready) begin
				beat_cnt <= beat_cnt + BEAT_W'(1);
			end
			if (fill.tag_set) begin
				rr_way <= {rr_way[`DCACHE_WAYS-2:0], rr_way[`DCACHE_WAYS-1]};
			end
		end
	end

	// uncached read beat, shown on dout in the ready cycle
	always_ff @(posedge clk) begin
		if (state == R_DEV && rvalid && rready) begin
			dev_data <= rdata;
		end
	end

endmodule

//--- logic/dcache_data_array.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_data_array import axi_pkg::*, dcache_pkg::*; (
	input  logic         clk,
	input  dcache_addr_u addr,
	dcache_fill_if.data  fill,
	input  axi_data_t    dev_data,
	output axi_data_t    dout
);

	localparam int STRB_W = $bits(axi_strb_t);
	localparam int DATA_W = $bits(axi_data_t);

	logic [DATA_W-1:0]   mask_bits;
	logic [2*DATA_W-1:0] bwe;
	logic [2*DATA_W-1:0] wline;
	logic [2*DATA_W-1:0] rline [`DCACHE_WAYS];
	logic [2*DATA_W-1:0] line_sel;
	way_vec_t            rd_way;

	// byte mask to bit enables
	always_comb begin
		for (int i = 0; i < STRB_W; i++) begin
			mask_bits[8*i +: 8] = {8{fill.sram_mask[i]}};
		end
	end

	// the other half of the row is left untouched
	assign bwe   = fill.sram_half ? {mask_bits, {DATA_W{1'b0}}} :
		{{DATA_W{1'b0}}, mask_bits};
	assign wline = fill.sram_half ? {fill.sram_wdata, {DATA_W{1'b0}}} :
		{{DATA_W{1'b0}}, fill.sram_wdata};

	for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
		sram_128x64 sram_inst (
			.clk   (clk),
			.en    (fill.sram_en[w]),
			.we    (fill.sram_we),
			.bwe   (bwe),
			.row   (fill.sram_row),
			.wdata (wline),
			.rdata (rline[w])
		);
	end

	// which way was read last edge, empty after writes and idle cycles
	always_ff @(posedge clk) begin
		rd_way <= fill.sram_en & {`DCACHE_WAYS{~fill.sram_we}};
	end

	always_comb begin
		line_sel = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			if (rd_way[w]) begin
				line_sel = line_sel | rline[w];
			end
		end
		// core holds addr until ready, so its half bit still picks the dword
		if (rd_way == '0) begin
			dout = dev_data;
		end else if (addr.cache.half) begin
			dout = line_sel[2*DATA_W-1:DATA_W];
		end else begin
			dout = line_sel[DATA_W-1:0];
		end
	end

endmodule

//--- logic/dcache_fill_if.sv
`timescale 1ns/100ps

interface dcache_fill_if import axi_pkg::*, dcache_pkg::*; ();

	way_vec_t  sram_en;
	logic      sram_we;
	logic [5:0] sram_row;
	logic      sram_half;
	axi_data_t sram_wdata;
	axi_strb_t sram_mask;
	// marks way sram_en of the indexed set valid
	logic      tag_set;

	modport ctrl (
		output sram_en, sram_we, sram_row, sram_half,
		output sram_wdata, sram_mask, tag_set
	);

	modport tags (
		input sram_en, tag_set
	);

	modport data (
		input sram_en, sram_we, sram_row, sram_half,
		input sram_wdata, sram_mask
	);

endinterface

//--- logic/dcache_pkg.sv
package dcache_pkg;

	// the core address, split either for lookup or for the bus burst
	typedef union packed {
		struct packed {
			logic [21:0] tag;
			logic [3:0]  index;
			logic [1:0]  row;
			logic        half;
			logic [2:0]  offset;
		} cache;
		struct packed {
			logic [25:0] line;
			logic [2:0]  beat;
			logic [2:0]  offset;
		} bus;
	} dcache_addr_u;

	typedef enum logic [2:0] {
		IDLE,
		AW_REQ,
		W_DATA,
		B_WAIT,
		AR_REQ,
		R_FILL,
		R_DEV
	} dcache_state_e;

	// one-hot way, or empty for none
	typedef logic [3:0] way_vec_t;

endpackage

//--- logic/dcache_tag_array.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_tag_array import dcache_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  dcache_addr_u addr,
	dcache_fill_if.tags  fill,
	output way_vec_t     way_hit,
	output way_vec_t     way_free
);

	localparam int TAG_W = $bits(addr.cache.tag);

	logic [TAG_W-1:0] tag_mem   [`DCACHE_SETS][`DCACHE_WAYS];
	logic             valid_mem [`DCACHE_SETS][`DCACHE_WAYS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < `DCACHE_SETS; s++) begin
				for (int w = 0; w < `DCACHE_WAYS; w++) begin
					valid_mem[s][w] <= 1'b0;
					tag_mem[s][w]   <= '0;
				end
			end
		end else if (fill.tag_set) begin
			// end of a refill, the way being filled takes the tag
			for (int w = 0; w < `DCACHE_WAYS; w++) begin
				if (fill.sram_en[w]) begin
					valid_mem[addr.cache.index][w] <= 1'b1;
					tag_mem[addr.cache.index][w]   <= addr.cache.tag;
				end
			end
		end
	end

	always_comb begin
		way_hit  = '0;
		way_free = '0;
		for (int w = 0; w < `DCACHE_WAYS; w++) begin
			way_hit[w] = valid_mem[addr.cache.index][w] &&
				(tag_mem[addr.cache.index][w] == addr.cache.tag);
		end
		// scan downward so the lowest invalid way wins
		for (int w = `DCACHE_WAYS - 1; w >= 0; w--) begin
			if (!valid_mem[addr.cache.index][w]) begin
				way_free = way_vec_t'(1) << w;
			end
		end
	end

endmodule

//--- logic/dcache_top.sv
`timescale 1ns/100ps

module dcache_top import axi_pkg::*, dcache_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// core side
	input  logic      valid,
	input  logic      wren,
	input  axi_addr_t addr,
	input  axi_data_t din,
	input  axi_strb_t mask,
	output logic      ready,
	output axi_data_t dout,
	// read address and data
	output axi_addr_t araddr,
	output axi_len_t  arlen,
	output logic      arvalid,
	input  logic      arready,
	input  axi_data_t rdata,
	input  logic      rlast,
	input  logic      rvalid,
	// write address, data and response
	output axi_addr_t awaddr,
	output logic      awvalid,
	input  logic      awready,
	output axi_data_t wdata,
	output axi_strb_t wstrb,
	output logic      wlast,
	output logic      wvalid,
	input  logic      wready,
	input  logic      bvalid
);

	dcache_addr_u core_addr;
	way_vec_t     way_hit;
	way_vec_t     way_free;
	axi_data_t    dev_data;

	assign core_addr = addr;

	dcache_fill_if fill ();

	dcache_ctrl dcache_ctrl_inst (
		.clk      (clk),
		.rst      (rst),
		.valid    (valid),
		.wren     (wren),
		.addr     (core_addr),
		.din      (din),
		.mask     (mask),
		.ready    (ready),
		.way_hit  (way_hit),
		.way_free (way_free),
		.fill     (fill.ctrl),
		.dev_data (dev_data),
		.araddr   (araddr),
		.arlen    (arlen),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rlast    (rlast),
		.rvalid   (rvalid),
		.awaddr   (awaddr),
		.awvalid  (awvalid),
		.awready  (awready),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wlast    (wlast),
		.wvalid   (wvalid),
		.wready   (wready),
		.bvalid   (bvalid)
	);

	dcache_tag_array dcache_tag_array_inst (
		.clk      (clk),
		.rst      (rst),
		.addr     (core_addr),
		.fill     (fill.tags),
		.way_hit  (way_hit),
		.way_free (way_free)
	);

	dcache_data_array dcache_data_array_inst (
		.clk      (clk),
		.addr     (core_addr),
		.fill     (fill.data),
		.dev_data (dev_data),
		.dout     (dout)
	);

endmodule

//--- logic/sram_128x64.sv
`timescale 1ns/100ps

module sram_128x64 (
	input  logic         clk,
	input  logic         en,
	input  logic         we,
	input  logic [127:0] bwe,
	input  logic [5:0]   row,
	input  logic [127:0] wdata,
	output logic [127:0] rdata
);

	logic [127:0] mem [64];

	// one access per edge, read data registered
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				// only bits with bwe set change
				mem[row] <= (mem[row] & ~bwe) | (wdata & bwe);
			end else begin
				rdata <= mem[row];
			end
		end
	end

endmodule

//--- sim/dcache_props.sv
`timescale 1ns/100ps

module dcache_props import axi_pkg::*, dcache_pkg::*; (
	input logic          clk,
	input logic          rst,
	input logic          ready,
	input logic          arvalid,
	input logic          arready,
	input axi_addr_t     araddr,
	input logic          awvalid,
	input logic          awready,
	input axi_addr_t     awaddr,
	input logic          wvalid,
	input logic          wready,
	input axi_data_t     wdata,
	input dcache_state_e state
);

	// FSM idle and outputs quiet right after reset
	assert property (@(posedge clk)
		rst |=> state == IDLE && !ready && !arvalid && !awvalid && !wvalid)
		else $error("controller not idle or bus active after reset");

	assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
		else $error("ready high for two cycles");

	// a valid without its ready is held with stable fields
	assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("AR channel dropped or changed before arready");

	assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("AW channel dropped or changed before awready");

	assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else $error("W channel dropped or changed before wready");

endmodule

bind dcache_ctrl dcache_props dcache_props_inst (
	.clk     (clk),
	.rst     (rst),
	.ready   (ready),
	.arvalid (arvalid),
	.arready (arready),
	.araddr  (araddr),
	.awvalid (awvalid),
	.awready (awready),
	.awaddr  (awaddr),
	.wvalid  (wvalid),
	.wready  (wready),
	.wdata   (wdata),
	.state   (state)
);

//--- sim/dcache_tb.sv
`timescale 1ns/100ps
`include "dcache_consts.svh"

module dcache_tb import axi_pkg::*; ();

	// about 30 accesses of at most ~100 cycles each with random gaps
	localparam int MAX_CYCLES = 4000;

	logic      clk;
	logic      rst;
	logic      valid;
	logic      wren;
	axi_addr_t addr;
	axi_data_t din;
	axi_strb_t mask;
	logic      ready;
	axi_data_t dout;
	axi_addr_t araddr;
	axi_len_t  arlen;
	logic      arvalid;
	logic      arready;
	axi_data_t rdata;
	logic      rlast;
	logic      rvalid;
	axi_addr_t awaddr;
	logic      awvalid;
	logic      awready;
	axi_data_t wdata;
	axi_strb_t wstrb;
	logic      wlast;
	logic      wvalid;
	logic      wready;
	logic      bvalid;

	// memory model state, keyed by dword address
	logic [63:0] mem [logic [28:0]];
	int          ar_count;
	int          aw_count;
	int          fill_count;
	axi_len_t    last_arlen;
	axi_addr_t   last_araddr;
	axi_strb_t   last_wstrb;
	logic        burst_on;
	axi_addr_t   burst_addr;
	axi_len_t    burst_len;
	int          beat;
	logic        aw_pending;
	axi_addr_t   aw_addr;
	logic        b_pending;

	int errors;
	int checks;
	int cycles;

	dcache_top dcache_top_inst (.*);

	always #2 clk = ~clk;

	function automatic axi_data_t model_word(axi_addr_t a);
		axi_addr_t al;
		al = a & ~32'h7;
		if (mem.exists(al[31:3])) begin
			return mem[al[31:3]];
		end
		return {~al, al ^ 32'h3c5a_96e1};
	endfunction

	function automatic axi_data_t merge_bytes(axi_data_t old, axi_data_t nw, axi_strb_t m);
		axi_data_t r;
		r = old;
		for (int i = 0; i < 8; i++) begin
			if (m[i]) r[8*i +: 8] = nw[8*i +: 8];
		end
		return r;
	endfunction

	task automatic check_value(string name, logic [63:0] exp, logic [63:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h actual %h", name, exp, act);
		end
	endtask

	// AXI memory model, samples at the edge and drives 1 ns later
	always @(posedge clk) begin
		if (rst) begin
			burst_on   = 1'b0;
			aw_pending = 1'b0;
			b_pending  = 1'b0;
		end else begin
			if (arvalid && arready) begin
				ar_count++;
				last_arlen  = arlen;
				last_araddr = araddr;
				burst_on    = 1'b1;
				burst_addr  = araddr;
				burst_len   = arlen;
				beat        = 0;
			end else if (rvalid) begin
				if (rlast) begin
					burst_on = 1'b0;
					if (burst_len == `DCACHE_BEATS - 1) fill_count++;
				end
				beat++;
			end
			if (awvalid && awready) begin
				aw_count++;
				aw_addr    = awaddr;
				aw_pending = 1'b1;
			end
			if (wvalid && wready) begin
				// every write is a single beat
				check_value("single beat wlast", 1, wlast);
				mem[aw_addr[31:3]] = merge_bytes(model_word(aw_addr), wdata, wstrb);
				last_wstrb = wstrb;
				aw_pending = 1'b0;
				b_pending  = 1'b1;
			end else if (bvalid) begin
				b_pending = 1'b0;
			end
		end
		#1;
		arready = !rst && ($urandom % 3 != 0);
		awready = !rst && ($urandom % 3 != 0);
		wready  = aw_pending && ($urandom % 3 != 0);
		bvalid  = b_pending && !(wvalid && wready) && ($urandom % 2 == 0);
		rvalid  = burst_on && !(arvalid && arready) && ($urandom % 4 != 0);
		rdata   = model_word(burst_addr + 32'(8 * beat));
		rlast   = rvalid && (beat == int'(burst_len));
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// one core access, returns dout and the number of edges until ready
	task automatic access(input logic wr, input axi_addr_t a, input axi_data_t d,
		input axi_strb_t m, output axi_data_t rd, output int lat);
		@(posedge clk);
		#1;
		valid = 1'b1;
		wren  = wr;
		addr  = a;
		din   = d;
		mask  = m;
		lat   = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!ready);
		rd = dout;
		#1;
		valid = 1'b0;
	endtask

	task automatic reset_and_first_miss();
		axi_data_t rd;
		int        lat;
		int        ar0;
		check_value("reset ready", 0, ready);
		check_value("reset arvalid", 0, arvalid);
		check_value("reset awvalid", 0, awvalid);
		check_value("reset wvalid", 0, wvalid);
		ar0 = ar_count;
		access(0, 32'h1000_0058, '0, '0, rd, lat);
		check_value("first miss data", model_word(32'h1000_0058), rd);
		check_value("first miss AR count", ar0 + 1, ar_count);
		check_value("first miss arlen", 7, last_arlen);
		check_value("first miss araddr", 32'h1000_0040, last_araddr);
	endtask

	task automatic reread_line();
		axi_data_t rd;
		int        lat;
		int        ar0;
		ar0 = ar_count;
		for (int i = 0; i < 8; i++) begin
			access(0, 32'h1000_0040 + 32'(8 * i), '0, '0, rd, lat);
			check_value("reread data", model_word(32'h1000_0040 + 32'(8 * i)), rd);
			// valid sampled at the first edge, ready seen at the second
			check_value("reread latency", 2, lat);
		end
		check_value("reread AR count", ar0, ar_count);
	endtask

	task automatic write_hit();
		axi_data_t rd;
		axi_data_t exp;
		int        lat;
		int        ar0;
		int        aw0;
		ar0 = ar_count;
		aw0 = aw_count;
		exp = merge_bytes(model_word(32'h1000_0060), 64'hdead_beef_0123_4567, 8'h3c);
		access(1, 32'h1000_0060, 64'hdead_beef_0123_4567, 8'h3c, rd, lat);
		check_value("write hit AW count", aw0 + 1, aw_count);
		check_value("write hit wstrb", 8'h3c, last_wstrb);
		access(0, 32'h1000_0060, '0, '0, rd, lat);
		check_value("write hit read", exp, rd);
		check_value("write hit model", exp, model_word(32'h1000_0060));
		check_value("write hit AR count", ar0, ar_count);
	endtask

	task automatic write_miss();
		axi_data_t rd;
		axi_data_t exp;
		int        lat;
		int        ar0;
		int        aw0;
		ar0 = ar_count;
		aw0 = aw_count;
		exp = merge_bytes(model_word(32'h1000_0088), 64'h0f1e_2d3c_4b5a_6978, 8'hf0);
		access(1, 32'h1000_0088, 64'h0f1e_2d3c_4b5a_6978, 8'hf0, rd, lat);
		check_value("write miss AW count", aw0 + 1, aw_count);
		check_value("write miss AR count", ar0 + 1, ar_count);
		access(0, 32'h1000_0088, '0, '0, rd, lat);
		check_value("write miss read", exp, rd);
		check_value("write miss no AR", ar0 + 1, ar_count);
	endtask

	task automatic set_capacity();
		axi_data_t rd;
		axi_addr_t a;
		int        lat;
		int        ar0;
		int        victim;
		// index 7, tag changes in bit 10 and up
		for (int k = 0; k < 4; k++) begin
			a = 32'h2000_01c8 + 32'(k * 32'h400);
			access(0, a, '0, '0, rd, lat);
			check_value("capacity fill", model_word(a), rd);
		end
		ar0 = ar_count;
		for (int k = 0; k < 4; k++) begin
			a = 32'h2000_01d0 + 32'(k * 32'h400);
			access(0, a, '0, '0, rd, lat);
			check_value("capacity resident", model_word(a), rd);
		end
		check_value("capacity resident AR", ar0, ar_count);
		// set is full, rotating pick advances once per line fill
		victim = fill_count % `DCACHE_WAYS;
		a = 32'h2000_01c0 + 32'(4 * 32'h400);
		access(0, a, '0, '0, rd, lat);
		check_value("capacity fifth", model_word(a), rd);
		check_value("capacity fifth AR", ar0 + 1, ar_count);
		for (int k = 0; k < 4; k++) begin
			if (k != victim) begin
				a = 32'h2000_01f8 + 32'(k * 32'h400);
				access(0, a, '0, '0, rd, lat);
				check_value("capacity kept", model_word(a), rd);
			end
		end
		check_value("capacity kept AR", ar0 + 1, ar_count);
		a = 32'h2000_01f8 + 32'(victim * 32'h400);
		access(0, a, '0, '0, rd, lat);
		check_value("capacity evicted", model_word(a), rd);
		check_value("capacity evicted AR", ar0 + 2, ar_count);
	endtask

	task automatic device_region();
		axi_data_t rd;
		axi_data_t exp;
		int        lat;
		int        ar0;
		int        aw0;
		for (int i = 0; i < 2; i++) begin
			ar0 = ar_count;
			access(0, `DCACHE_DEV_BASE + 32'h100, '0, '0, rd, lat);
			check_value("device read", model_word(`DCACHE_DEV_BASE + 32'h100), rd);
			check_value("device read AR", ar0 + 1, ar_count);
			check_value("device arlen", 0, last_arlen);
		end
		ar0 = ar_count;
		aw0 = aw_count;
		exp = merge_bytes(model_word(`DCACHE_DEV_BASE + 32'h108), 64'h1122_3344_5566_7788,
			8'h0f);
		access(1, `DCACHE_DEV_BASE + 32'h108, 64'h1122_3344_5566_7788, 8'h0f, rd, lat);
		check_value("device write AW", aw0 + 1, aw_count);
		check_value("device write no AR", ar0, ar_count);
		access(0, `DCACHE_DEV_BASE + 32'h108, '0, '0, rd, lat);
		check_value("device readback", exp, rd);
		check_value("device readback AR", ar0 + 1, ar_count);
	endtask

	initial begin
		void'($urandom(32'h3e92b14f));
		clk        = 1'b0;
		rst        = 1'b1;
		valid      = 1'b0;
		wren       = 1'b0;
		addr       = '0;
		din        = '0;
		mask       = '0;
		arready    = 1'b0;
		awready    = 1'b0;
		wready     = 1'b0;
		bvalid     = 1'b0;
		rvalid     = 1'b0;
		rlast      = 1'b0;
		rdata      = '0;
		ar_count   = 0;
		aw_count   = 0;
		fill_count = 0;
		burst_addr = '0;
		burst_len  = '0;
		beat       = 0;
		errors     = 0;
		checks     = 0;
		cycles     = 0;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		reset_and_first_miss();
		reread_line();
		write_hit();
		write_miss();
		set_capacity();
		device_region();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
